/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fibSeqTb
FILELIST  := fibSeq.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAILMSG   := FAIL: see errors above
PASSMSG   := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* fibSeq.f */
+incdir+logic
logic/fibSeqPkg.sv
logic/fibSequencer.sv
logic/fibRegFile.sv
logic/fibAlu.sv
logic/fibBusMux.sv
logic/fibHostPort.sv
logic/fibSeqTop.sv
tb/fibSeq_asserts.sv
tb/fibSeqTb.sv

/* logic/fibAlu.sv */
`include "fibSeq_defines.svh"

module fibAlu import fibSeqPkg::*; (
    input  aluOp_e op,
    input  data_t  a,
    input  data_t  b,
    output data_t  result,
    output logic   carry
);

    // one extra bit to catch the carry out
    logic [`FIB_DATA_W:0] sum;

    assign sum = {1'b0, a} + {1'b0, b};

    always_comb begin
        case (op)
            ADD: begin
                result = sum[`FIB_DATA_W-1:0]; // wraps at 16 bits
                carry  = sum[`FIB_DATA_W];
            end
            default: begin
                // NOP and anything unknown just pass a
                result = a;
                carry  = 1'b0;
            end
        endcase
    end

endmodule

/* logic/fibBusMux.sv */
`include "fibSeq_defines.svh"

module fibBusMux import fibSeqPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  bufSel_e  bufSel,
    input  logic     seedSel,
    input  logic     writeEn,
    input  logic     clearFlags,
    input  data_t    seed0,
    input  data_t    seed1,
    input  data_t    aluResult,
    input  data_t    regData,
    input  logic     aluCarry,
    input  wbAddr_u  hostSel,
    input  logic     busy,
    input  logic     done,
    input  data_t    ctrlSeed0,
    input  data_t    ctrlSeed1,
    output data_t    writeData,
    output data_t    hostRead
);

    logic    overflow;
    status_t status;

    // write-back word
    assign writeData = (bufSel == ALU) ? aluResult : (seedSel ? seed1 : seed0);

    //////////////////////////////
    // sticky overflow
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (clearFlags && !busy) begin
            overflow <= 1'b0; // a start that the sequencer accepts
        end else if (writeEn && bufSel == ALU && aluCarry) begin
            overflow <= 1'b1;
        end
    end

    //////////////////////////////
    // host read decode
    //////////////////////////////

    always_comb begin
        status          = '0;
        status.busy     = busy;
        status.done     = done;
        status.overflow = overflow;

        hostRead = '0;
        if (hostSel.regAddr.page) begin
            hostRead = regData;
        end else begin
            case (hostSel.ctrlAddr.ctrlSel)
                `FIB_CSEL_SEED0:  hostRead = ctrlSeed0;
                `FIB_CSEL_SEED1:  hostRead = ctrlSeed1;
                `FIB_CSEL_STATUS: hostRead = data_t'(status);
                default:          hostRead = '0; // control reg is write only
            endcase
        end
    end

endmodule

/* logic/fibHostPort.sv */
`include "fibSeq_defines.svh"

module fibHostPort import fibSeqPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wbAddr_u adr,
    input  data_t   datW,
    output logic    ack,
    output data_t   seed0,
    output data_t   seed1,
    output logic    start,
    output wbAddr_u hostSel
);

    logic request;
    logic ctrlWrite;

    // new transfer, not the tail of one already acked
    assign request   = cyc && stb && !ack;
    assign ctrlWrite = request && we && !adr.ctrlAddr.page;

    //////////////////////////////
    // classic handshake
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack     <= 1'b0;
            hostSel <= '0;
        end else begin
            ack <= request; // one wait state, one cycle high
            if (request) begin
                hostSel <= adr; // read path decodes this while ack is up
            end
        end
    end

    //////////////////////////////
    // control page writes
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seed0 <= '0;
            seed1 <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (ctrlWrite) begin
                case (adr.ctrlAddr.ctrlSel)
                    `FIB_CSEL_SEED0: seed0 <= datW;
                    `FIB_CSEL_SEED1: seed1 <= datW;
                    `FIB_CSEL_CTRL:  start <= datW[0]; // pulse, clears next cycle
                    default: ;
                endcase
            end
            // page 1 writes are acked and dropped
        end
    end

endmodule

/* logic/fibRegFile.sv */
`include "fibSeq_defines.svh"

module fibRegFile import fibSeqPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    writeEn,
    input  regIdx_t writeIdx,
    input  regIdx_t readIdxA,
    input  regIdx_t readIdxB,
    input  regIdx_t hostIdx,
    input  data_t   writeData,
    output data_t   readA,
    output data_t   readB,
    output data_t   hostData
);

    data_t regs [`FIB_REG_N];

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FIB_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData; // lands at end of step
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // operands for the alu
    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

    // host side, independent of the sequencer
    assign hostData = regs[hostIdx];

endmodule

/* logic/fibSeqPkg.sv */
`include "fibSeq_defines.svh"

package fibSeqPkg;

    typedef logic [`FIB_DATA_W-1:0] data_t;
    typedef logic [`FIB_IDX_W-1:0]  regIdx_t;

    // alu opcodes, byte wide
    typedef enum logic [7:0] {
        NOP = 8'h00, // pass operand a
        ADD = 8'h01
    } aluOp_e;

    // write-back source
    typedef enum logic {
        SEED = 1'b0,
        ALU  = 1'b1
    } bufSel_e;

    typedef struct packed {
        regIdx_t  writeIdx;
        regIdx_t  readIdxA;
        regIdx_t  readIdxB;
        aluOp_e   aluOp;
        bufSel_e  bufSel;
        logic     seedSel;    // 0 picks seed 0
        logic     regWriteEn;
    } seqCtrl_t;

    typedef struct packed {
        logic [`FIB_DATA_W-4:0] reserved; // reads as zero
        logic                   overflow;
        logic                   done;
        logic                   busy;
    } status_t;

    // page bit selects register view or control view
    typedef union packed {
        struct packed {
            logic    page;
            regIdx_t regIdx;
        } regAddr;
        struct packed {
            logic                   page;
            logic [`FIB_ADDR_W-2:0] ctrlSel;
        } ctrlAddr;
    } wbAddr_u;

endpackage

/* logic/fibSeqTop.sv */
module fibSeqTop import fibSeqPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wbAddr_u adr,
    input  data_t   datW,
    output logic    ack,
    output data_t   datR
);

    seqCtrl_t ctrl;
    wbAddr_u  hostSel;
    data_t    seed0;
    data_t    seed1;
    data_t    readA;
    data_t    readB;
    data_t    hostData;
    data_t    aluResult;
    data_t    writeData;
    logic     aluCarry;
    logic     start;
    logic     busy;
    logic     done;

    //////////////////////////////
    // bus side
    //////////////////////////////

    fibHostPort hostPort (
        .clk     (clk),
        .reset   (reset),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datW    (datW),
        .ack     (ack),
        .seed0   (seed0),
        .seed1   (seed1),
        .start   (start),
        .hostSel (hostSel)
    );

    fibSequencer sequencer (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    //////////////////////////////
    // datapath
    //////////////////////////////

    fibRegFile regFile (
        .clk       (clk),
        .reset     (reset),
        .writeEn   (ctrl.regWriteEn),
        .writeIdx  (ctrl.writeIdx),
        .readIdxA  (ctrl.readIdxA),
        .readIdxB  (ctrl.readIdxB),
        .hostIdx   (hostSel.regAddr.regIdx),
        .writeData (writeData),
        .readA     (readA),
        .readB     (readB),
        .hostData  (hostData)
    );

    fibAlu alu (
        .op     (ctrl.aluOp),
        .a      (readA),
        .b      (readB),
        .result (aluResult),
        .carry  (aluCarry)
    );

    fibBusMux busMux (
        .clk        (clk),
        .reset      (reset),
        .bufSel     (ctrl.bufSel),
        .seedSel    (ctrl.seedSel),
        .writeEn    (ctrl.regWriteEn),
        .clearFlags (start),
        .seed0      (seed0),
        .seed1      (seed1),
        .aluResult  (aluResult),
        .regData    (hostData),
        .aluCarry   (aluCarry),
        .hostSel    (hostSel),
        .busy       (busy),
        .done       (done),
        .ctrlSeed0  (seed0),
        .ctrlSeed1  (seed1),
        .writeData  (writeData),
        .hostRead   (datR)
    );

endmodule

/* logic/fibSeq_defines.svh */
`ifndef FIB_SEQ_DEFINES_SVH
`define FIB_SEQ_DEFINES_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////

`define FIB_DATA_W 16 // one register word
`define FIB_REG_N  16 // register file depth
`define FIB_IDX_W  4  // log2 of FIB_REG_N

// sequencer length, one register written per step
`define FIB_STEP_N 16

//////////////////////////////
// wishbone address map
//////////////////////////////

`define FIB_ADDR_W 5 // word address, page bit on top

// control page selects
`define FIB_CSEL_SEED0  4'd0
`define FIB_CSEL_SEED1  4'd1
`define FIB_CSEL_CTRL   4'd2 // bit 0 is start, write only
`define FIB_CSEL_STATUS 4'd3 // read only

`endif

/* logic/fibSequencer.sv */
`include "fibSeq_defines.svh"

module fibSequencer import fibSeqPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    output seqCtrl_t ctrl,
    output logic     busy,
    output logic     done
);

    // states 0..15 are the steps themselves
    localparam logic [4:0] IDLE     = 5'(`FIB_STEP_N);
    localparam logic [4:0] DONE     = 5'(`FIB_STEP_N + 1);
    localparam logic [4:0] LASTSTEP = 5'(`FIB_STEP_N - 1);

    logic [4:0] state;
    regIdx_t    stepIdx;

    assign stepIdx = state[`FIB_IDX_W-1:0];
    assign busy    = (state < 5'(`FIB_STEP_N));
    assign done    = (state == DONE);

    //////////////////////////////
    // state counter
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else if (busy) begin
            if (state == LASTSTEP) begin
                state <= DONE;
            end else begin
                state <= state + 5'd1;
            end
        end else if (start) begin
            // from idle or done, start always lands in step 0
            state <= 5'd0;
        end
    end

    //////////////////////////////
    // per-step control decode
    //////////////////////////////

    always_comb begin
        ctrl            = '0;
        ctrl.aluOp      = NOP;
        ctrl.bufSel     = SEED;
        if (busy) begin
            ctrl.writeIdx   = stepIdx;
            ctrl.regWriteEn = 1'b1;
            if (stepIdx < regIdx_t'(2)) begin
                // mov rk, seed k
                ctrl.seedSel = stepIdx[0];
            end else begin
                // add rk, r(k-1), r(k-2)
                ctrl.readIdxA = stepIdx - regIdx_t'(1);
                ctrl.readIdxB = stepIdx - regIdx_t'(2);
                ctrl.aluOp    = ADD;
                ctrl.bufSel   = ALU;
            end
        end
    end

endmodule

/* tb/fibSeqTb.sv */
`include "fibSeq_defines.svh"

module fibSeqTb import fibSeqPkg::*; ();

    localparam int MAX_TESTS  = 16;
    localparam int DONE_LIMIT = 18; // cycles from start ack to done

    logic    clk;
    logic    reset;
    logic    cyc;
    logic    stb;
    logic    we;
    wbAddr_u adr;
    data_t   datW;
    logic    ack;
    data_t   datR;

    logic [31:0] lcgState = 32'hc3fb;
    int          cycleCount = 0;
    int          cycleLimit = 50;
    int          lastAckCycle;
    int          numTests;
    int          startAck;
    data_t       word;
    data_t       goldSeed0 [MAX_TESTS];
    data_t       goldSeed1 [MAX_TESTS];
    logic        goldOvf [MAX_TESTS];
    data_t       goldRegs [MAX_TESTS][`FIB_REG_N];

    fibSeqTop UUT (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datW  (datW),
        .ack   (ack),
        .datR  (datR)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleCount);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic wbAddr_u ctrlAddress(logic [3:0] sel);
        wbAddr_u a;
        a.ctrlAddr.page    = 1'b0;
        a.ctrlAddr.ctrlSel = sel;
        return a;
    endfunction

    function automatic wbAddr_u regAddress(int idx);
        wbAddr_u a;
        a.regAddr.page   = 1'b1;
        a.regAddr.regIdx = regIdx_t'(idx);
        return a;
    endfunction

    //////////////////////////////
    // wishbone master
    //////////////////////////////

    task automatic waitForAck();
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        lastAckCycle = cycleCount;
    endtask

    task automatic busTransfer(input logic write, input wbAddr_u addr, input data_t wdata,
                               output data_t rdata);
        logic [31:0] r;
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= write;
        adr  <= addr;
        datW <= wdata;
        waitForAck();
        rdata = datR; // valid while ack is up
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        r = nextRandom();
        repeat (r[31:30]) @(posedge clk); // 0 to 3 idle cycles
    endtask

    task automatic busWrite(input wbAddr_u addr, input data_t data);
        data_t ignored;
        busTransfer(1'b1, addr, data, ignored);
    endtask

    task automatic busRead(input wbAddr_u addr, output data_t data);
        busTransfer(1'b0, addr, '0, data);
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic checkWord(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkStatus(input string name, input status_t got, input status_t exp);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic waitForDone(input int ackCycle);
        data_t   w;
        status_t st;
        st = '0;
        while (!st.done) begin
            busRead(ctrlAddress(`FIB_CSEL_STATUS), w);
            st = status_t'(w);
            if (!st.done && lastAckCycle - ackCycle >= DONE_LIMIT) begin
                $display("done still low %0d cycles after the start ack",
                         lastAckCycle - ackCycle);
                abortRun();
            end
        end
    endtask

    // final status and all registers of golden test t
    task automatic checkRun(input int t);
        status_t exp;
        data_t   w;
        exp          = '0;
        exp.done     = 1'b1;
        exp.overflow = goldOvf[t];
        busRead(ctrlAddress(`FIB_CSEL_STATUS), w);
        checkStatus("status", status_t'(w), exp);
        for (int i = 0; i < `FIB_REG_N; i++) begin
            busRead(regAddress(i), w);
            checkWord($sformatf("r%0d", i), w, goldRegs[t][i]);
        end
    endtask

    task automatic runTest(input int t);
        data_t w;
        busWrite(ctrlAddress(`FIB_CSEL_SEED0), goldSeed0[t]);
        busWrite(ctrlAddress(`FIB_CSEL_SEED1), goldSeed1[t]);
        busRead(ctrlAddress(`FIB_CSEL_SEED0), w);
        checkWord("seed0", w, goldSeed0[t]);
        busRead(ctrlAddress(`FIB_CSEL_SEED1), w);
        checkWord("seed1", w, goldSeed1[t]);
        busWrite(ctrlAddress(`FIB_CSEL_CTRL), 16'h0001);
        waitForDone(lastAckCycle);
        checkRun(t);
    endtask

    task automatic readGolden();
        int    fd;
        int    count;
        string line;
        data_t v [19];
        fd = $fopen("tb/fibSeq_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/fibSeq_golden.txt");
            abortRun();
        end
        numTests = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
            if (count != 19 || numTests >= MAX_TESTS) begin
                $display("golden file line not usable: %s", line);
                abortRun();
            end
            goldSeed0[numTests] = v[0];
            goldSeed1[numTests] = v[1];
            goldOvf[numTests]   = v[2][0];
            for (int i = 0; i < `FIB_REG_N; i++) begin
                goldRegs[numTests][i] = v[i + 3];
            end
            numTests++;
        end
        $fclose(fd);
        if (numTests == 0) begin
            $display("golden file holds no tests");
            abortRun();
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datW  = '0;
        readGolden();
        cycleLimit = (numTests + 3) * 200 + 50; // plus reset, map and busy phases
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        busRead(ctrlAddress(`FIB_CSEL_STATUS), word);
        checkStatus("status", status_t'(word), '0);
        busRead(ctrlAddress(`FIB_CSEL_SEED0), word);
        checkWord("seed0", word, '0);
        busRead(ctrlAddress(`FIB_CSEL_SEED1), word);
        checkWord("seed1", word, '0);
        for (int i = 0; i < `FIB_REG_N; i++) begin
            busRead(regAddress(i), word);
            checkWord($sformatf("r%0d", i), word, '0);
        end

        // unused control selects, control reg included
        for (int s = 2; s < 16; s++) begin
            if (s != 3) begin
                busRead(ctrlAddress(4'(s)), word);
                checkWord($sformatf("ctrl%0d", s), word, '0);
            end
        end

        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end

        // second start lands mid run, after steps 0 and 1
        busWrite(ctrlAddress(`FIB_CSEL_SEED0), goldSeed0[0]);
        busWrite(ctrlAddress(`FIB_CSEL_SEED1), goldSeed1[0]);
        busWrite(ctrlAddress(`FIB_CSEL_CTRL), 16'h0001);
        startAck = lastAckCycle;
        busWrite(ctrlAddress(`FIB_CSEL_SEED0), ~goldSeed0[0]);
        busWrite(ctrlAddress(`FIB_CSEL_CTRL), 16'h0001);
        waitForDone(startAck);
        checkRun(0);

        // page 1 writes are acked and dropped
        for (int i = 0; i < `FIB_REG_N; i++) begin
            busWrite(regAddress(i), data_t'(16'hbeef + i));
        end
        checkRun(0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* tb/fibSeq_asserts.sv */
module fibSeqAsserts (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic busy,
    input logic done,
    input logic regWriteEn
);

    // ack only answers a live request
    ackNeedsRequest: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
        else $error("ack high without cyc and stb");

    ackOneCycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack held high for two cycles");

    writeOnlyWhenBusy: assert property (@(posedge clk) disable iff (reset) regWriteEn |-> busy)
        else $error("register write outside a run");

    doneBusyExclusive: assert property (@(posedge clk) disable iff (reset) !(done && busy))
        else $error("done and busy high together");

endmodule

bind fibSeqTop fibSeqAsserts asserts (
    .clk        (clk),
    .reset      (reset),
    .cyc        (cyc),
    .stb        (stb),
    .ack        (ack),
    .busy       (busy),
    .done       (done),
    .regWriteEn (ctrl.regWriteEn)
);

/* tb/fibSeq_golden.txt */
# seed0 seed1 overflow, then expected r0 to r15, all hex
# rk = r(k-1) + r(k-2) wrapped to 16 bits, overflow set on any carry
0007 000d 0 0007 000d 0014 0021 0035 0056 008b 00e1 016c 024d 03b9 0606 09bf 0fc5 1984 2949
0000 0000 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0001 0001 0 0001 0001 0002 0003 0005 0008 000d 0015 0022 0037 0059 0090 00e9 0179 0262 03db
4000 6000 1 4000 6000 a000 0000 a000 a000 4000 e000 2000 0000 2000 2000 4000 6000 a000 0000
0003 0005 0 0003 0005 0008 000d 0015 0022 0037 0059 0090 00e9 0179 0262 03db 063d 0a18 1055
ffff 0001 1 ffff 0001 0000 0001 0001 0002 0003 0005 0008 000d 0015 0022 0037 0059 0090 00e9
0000 0001 0 0000 0001 0001 0002 0003 0005 0008 000d 0015 0022 0037 0059 0090 00e9 0179 0262
